/* verilog/mfp_pkg.sv */
// MFP shared definitions
`default_nettype none

package mfp_pkg;

	// register address map
	typedef logic [3:0] mfp_addr_t;

	localparam mfp_addr_t ADDR_GPIP = 4'd0;
	localparam mfp_addr_t ADDR_AER  = 4'd1;
	localparam mfp_addr_t ADDR_DDR  = 4'd2;
	localparam mfp_addr_t ADDR_IER  = 4'd3;
	localparam mfp_addr_t ADDR_IPR  = 4'd4;
	localparam mfp_addr_t ADDR_ISR  = 4'd5;
	localparam mfp_addr_t ADDR_IMR  = 4'd6;
	localparam mfp_addr_t ADDR_VR   = 4'd7;
	localparam mfp_addr_t ADDR_TACR = 4'd8;
	localparam mfp_addr_t ADDR_TBCR = 4'd9;
	localparam mfp_addr_t ADDR_TADR = 4'd10;
	localparam mfp_addr_t ADDR_TBDR = 4'd11;
	localparam mfp_addr_t ADDR_RSR  = 4'd12;
	localparam mfp_addr_t ADDR_TSR  = 4'd13;
	localparam mfp_addr_t ADDR_UDR  = 4'd14;

	// interrupt sources, higher number wins
	localparam int N_SRC = 8;
	localparam logic [2:0] SRC_GPIO0    = 3'd0;
	localparam logic [2:0] SRC_GPIO1    = 3'd1;
	localparam logic [2:0] SRC_GPIO2    = 3'd2;
	localparam logic [2:0] SRC_GPIO3    = 3'd3;
	localparam logic [2:0] SRC_TIMER_B  = 3'd4;
	localparam logic [2:0] SRC_TX_EMPTY = 3'd5;
	localparam logic [2:0] SRC_RX_FULL  = 3'd6;
	localparam logic [2:0] SRC_TIMER_A  = 3'd7;

	// timer control value to divide ratio, 0 stops the timer
	function automatic logic [7:0] mfp_prescale(input logic [2:0] ctrl);
		case (ctrl)
			3'd1:    return 8'd4;
			3'd2:    return 8'd10;
			3'd3:    return 8'd16;
			3'd4:    return 8'd50;
			3'd5:    return 8'd64;
			3'd6:    return 8'd100;
			3'd7:    return 8'd200;
			default: return 8'd0;
		endcase
	endfunction

	// vector register as written by software, and as sent on acknowledge
	typedef union packed {
		struct packed {
			logic [3:0] base;
			logic       sei;
			logic [2:0] unused;
		} ctrl;
		struct packed {
			logic [3:0] base;
			logic       zero;
			logic [2:0] channel;
		} vec;
	} mfp_vector_u;

endpackage

`default_nettype wire

/* verilog/mfp_bus.sv */
// MFP bus decode and GPIO port
`timescale 1ns/1ps
`default_nettype none

module mfp_bus (
	input  wire               iack,
	input  wire               reset,
	input  wire               sel_i,
	input  wire               we_i,
	input  mfp_pkg::mfp_addr_t addr_i,
	input  wire  [7:0]        wdata_i,
	output logic [7:0]        rdata_o,
	input  wire               int_ack_i,
	input  wire  [7:0]        gpio_i,
	output logic [7:0]        gpio_o,
	output logic [7:0]        gpio_oe_o,
	output logic [3:0]        edge_o,
	output logic              ta_ctrl_we_o,
	output logic              ta_data_we_o,
	output logic              tb_ctrl_we_o,
	output logic              tb_data_we_o,
	input  wire  [2:0]        ta_ctrl_i,
	input  wire  [7:0]        ta_data_i,
	input  wire  [2:0]        tb_ctrl_i,
	input  wire  [7:0]        tb_data_i,
	output logic [4:0]        intc_we_o,
	input  wire  [7:0]        ier_i,
	input  wire  [7:0]        ipr_i,
	input  wire  [7:0]        isr_i,
	input  wire  [7:0]        imr_i,
	input  wire  [7:0]        vr_i,
	input  wire  [7:0]        vector_i,
	output logic              udr_we_o,
	output logic              udr_re_o,
	input  wire  [7:0]        rx_data_i,
	input  wire               rx_avail_i,
	input  wire               tx_full_i
);
	import mfp_pkg::*;

	logic       wr;
	logic       rd;
	logic [7:0] gpip;
	logic [7:0] aer;
	logic [7:0] ddr;
	// synchronized pins and the previous sample of the four irq pins
	logic [7:0] gpio_q;
	logic [3:0] gpio_d;
	logic [3:0] rise;
	logic [3:0] fall;

	assign wr = sel_i & we_i;
	assign rd = sel_i & ~we_i;

	// timer strobes
	assign ta_ctrl_we_o = wr && (addr_i == ADDR_TACR);
	assign tb_ctrl_we_o = wr && (addr_i == ADDR_TBCR);
	assign ta_data_we_o = wr && (addr_i == ADDR_TADR);
	assign tb_data_we_o = wr && (addr_i == ADDR_TBDR);

	// bit order toward intc is IER, IPR, ISR, IMR, VR from bit 0 up
	assign intc_we_o = {wr && (addr_i == ADDR_VR), wr && (addr_i == ADDR_IMR),
		wr && (addr_i == ADDR_ISR), wr && (addr_i == ADDR_IPR),
		wr && (addr_i == ADDR_IER)};

	// serial data register, a read pops the receive FIFO
	assign udr_we_o = wr && (addr_i == ADDR_UDR);
	assign udr_re_o = rd && (addr_i == ADDR_UDR);

	always_ff @(posedge iack) begin
		if (reset) begin
			gpip   <= 8'h00;
			aer    <= 8'h00;
			ddr    <= 8'h00;
			gpio_q <= 8'h00;
			gpio_d <= 4'h0;
		end else begin
			gpio_q <= gpio_i;
			gpio_d <= gpio_q[3:0];
			if (wr && (addr_i == ADDR_GPIP))
				gpip <= wdata_i;
			if (wr && (addr_i == ADDR_AER))
				aer <= wdata_i;
			if (wr && (addr_i == ADDR_DDR))
				ddr <= wdata_i;
		end
	end

	assign gpio_o    = gpip;
	assign gpio_oe_o = ddr;

	// aer bit 1 picks the rising edge
	assign rise   = gpio_q[3:0] & ~gpio_d;
	assign fall   = ~gpio_q[3:0] & gpio_d;
	assign edge_o = (rise & aer[3:0]) | (fall & ~aer[3:0]);

	// acknowledge owns the data bus in its cycle
	always_comb begin
		rdata_o = 8'h00;
		if (int_ack_i) begin
			rdata_o = vector_i;
		end else if (rd) begin
			case (addr_i)
				// input pins read back through the synchronizer
				ADDR_GPIP: rdata_o = (gpio_q & ~ddr) | (gpip & ddr);
				ADDR_AER:  rdata_o = aer;
				ADDR_DDR:  rdata_o = ddr;
				ADDR_IER:  rdata_o = ier_i;
				ADDR_IPR:  rdata_o = ipr_i;
				ADDR_ISR:  rdata_o = isr_i;
				ADDR_IMR:  rdata_o = imr_i;
				ADDR_VR:   rdata_o = vr_i;
				ADDR_TACR: rdata_o = {5'b00000, ta_ctrl_i};
				ADDR_TBCR: rdata_o = {5'b00000, tb_ctrl_i};
				ADDR_TADR: rdata_o = ta_data_i;
				ADDR_TBDR: rdata_o = tb_data_i;
				ADDR_RSR:  rdata_o = {rx_avail_i, 7'b0000000};
				// buffer empty means room for one more byte
				ADDR_TSR:  rdata_o = {~tx_full_i, 7'b0000000};
				ADDR_UDR:  rdata_o = rx_data_i;
				default:   rdata_o = 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/mfp_timer.sv */
// MFP delay timer
`timescale 1ns/1ps
`default_nettype none

module mfp_timer (
	input  wire        iack,
	input  wire        reset,
	input  wire        ctrl_we_i,
	input  wire        data_we_i,
	input  wire  [7:0] wdata_i,
	output logic [2:0] ctrl_o,
	output logic [7:0] data_o,
	output logic       done_o
);
	import mfp_pkg::*;

	logic [2:0] ctrl;
	logic [7:0] reload;
	logic [7:0] count;
	logic [7:0] pre_cnt;
	logic       tick;

	// one tick every mfp_prescale(ctrl) cycles
	// stopped, the prescaler sits at zero and never meets its end value
	assign tick = (pre_cnt == mfp_prescale(ctrl) - 8'd1);

	always_ff @(posedge iack) begin
		if (reset) begin
			ctrl    <= 3'd0;
			reload  <= 8'h00;
			count   <= 8'h00;
			pre_cnt <= 8'h00;
		end else begin
			// control write restarts the prescaler
			if (ctrl_we_i) begin
				ctrl    <= wdata_i[2:0];
				pre_cnt <= 8'h00;
			end else if (ctrl == 3'd0 || tick) begin
				pre_cnt <= 8'h00;
			end else begin
				pre_cnt <= pre_cnt + 8'd1;
			end
			// data write wins over a tick in the same cycle
			if (data_we_i) begin
				reload <= wdata_i;
				count  <= wdata_i;
			end else if (tick) begin
				// zero counts as 256, it wraps to 255 first
				count <= (count == 8'd1) ? reload : count - 8'd1;
			end
		end
	end

	assign done_o = tick && (count == 8'd1) && !data_we_i;
	assign ctrl_o = ctrl;
	assign data_o = count;

	// a stopped timer stays quiet even across data writes
	a_stopped_quiet: assert property (@(posedge iack) disable iff (reset)
		(ctrl == 3'd0) |-> !done_o)
		else $error("timer done while stopped");

endmodule

`default_nettype wire

/* verilog/mfp_intc.sv */
// MFP interrupt controller
`timescale 1ns/1ps
`default_nettype none

module mfp_intc (
	input  wire        iack,
	input  wire        reset,
	input  wire  [7:0] src_i,
	input  wire  [4:0] we_i,
	input  wire  [7:0] wdata_i,
	input  wire        int_ack_i,
	output logic [7:0] ier_o,
	output logic [7:0] ipr_o,
	output logic [7:0] isr_o,
	output logic [7:0] imr_o,
	output logic [7:0] vr_o,
	output logic [7:0] vector_o,
	output logic       irq_o
);
	import mfp_pkg::*;

	logic [N_SRC-1:0] ier;
	logic [N_SRC-1:0] ipr;
	logic [N_SRC-1:0] isr;
	logic [N_SRC-1:0] imr;
	logic [N_SRC-1:0] ipr_n;
	logic [N_SRC-1:0] isr_n;
	mfp_vector_u      vr_q;
	mfp_vector_u      vec_w;
	logic [3:0]       pend;
	logic [3:0]       serv;

	// {valid, index} of the highest set bit
	function automatic logic [3:0] hi_bit(input logic [N_SRC-1:0] v);
		logic [3:0] r;
		r = 4'h0;
		for (int i = 0; i < N_SRC; i++) begin
			if (v[i])
				r = {1'b1, 3'(i)};
		end
		return r;
	endfunction

	assign pend  = hi_bit(ipr & imr);
	assign serv  = hi_bit(isr);
	// equal priority in service blocks too
	assign irq_o = pend[3] && (!serv[3] || pend[2:0] > serv[2:0]);

	always_comb begin
		ipr_n = ipr;
		isr_n = isr;
		if (int_ack_i)
			ipr_n[pend[2:0]] = 1'b0;
		// zero bits written to IER, IPR or ISR clear
		if (we_i[0])
			ipr_n = ipr_n & wdata_i;
		if (we_i[1])
			ipr_n = ipr_n & wdata_i;
		if (we_i[2])
			isr_n = isr_n & wdata_i;
		// new events from enabled sources
		ipr_n = ipr_n | (src_i & ier);
		// sei clear moves the acknowledged source into service
		if (int_ack_i && !vr_q.ctrl.sei)
			isr_n[pend[2:0]] = 1'b1;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			ier  <= '0;
			ipr  <= '0;
			isr  <= '0;
			imr  <= '0;
			vr_q <= '0;
		end else begin
			ipr <= ipr_n;
			isr <= isr_n;
			if (we_i[0])
				ier <= wdata_i;
			if (we_i[3])
				imr <= wdata_i;
			if (we_i[4]) begin
				vr_q.ctrl.base   <= wdata_i[7:4];
				vr_q.ctrl.sei    <= wdata_i[3];
				vr_q.ctrl.unused <= wdata_i[2:0];
			end
		end
	end

	// same byte seen as vector: base, zero, channel
	always_comb begin
		vec_w             = vr_q;
		vec_w.vec.zero    = 1'b0;
		vec_w.vec.channel = pend[2:0];
	end

	assign vector_o = vec_w;
	assign vr_o     = {vr_q.ctrl.base, vr_q.ctrl.sei, vr_q.ctrl.unused};
	assign ier_o    = ier;
	assign ipr_o    = ipr;
	assign isr_o    = isr;
	assign imr_o    = imr;

	// the CPU only acknowledges a raised request
	a_ack_needs_irq: assert property (@(posedge iack) disable iff (reset)
		int_ack_i |-> irq_o)
		else $error("acknowledge without request");

endmodule

`default_nettype wire

/* verilog/mfp_serial.sv */
// MFP serial FIFOs with credits
`timescale 1ns/1ps
`default_nettype none

module mfp_serial #(
	parameter int FIFO_DEPTH = 4,
	parameter int CREDIT_W   = 3
) (
	input  wire        iack,
	input  wire        reset,
	input  wire        udr_we_i,
	input  wire        udr_re_i,
	input  wire  [7:0] wdata_i,
	output logic [7:0] rx_data_o,
	output logic       rx_avail_o,
	output logic       tx_full_o,
	output logic       tx_empty_o,
	input  wire        tx_credit_i,
	output logic       tx_valid_o,
	output logic [7:0] tx_data_o,
	input  wire        rx_valid_i,
	input  wire  [7:0] rx_data_i,
	output logic       rx_credit_o
);
	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0]        tx_mem [FIFO_DEPTH];
	logic [7:0]        rx_mem [FIFO_DEPTH];
	// pointers carry one wrap bit above the index
	logic [AW:0]       tx_wp;
	logic [AW:0]       tx_rp;
	logic [AW:0]       rx_wp;
	logic [AW:0]       rx_rp;
	logic [CREDIT_W-1:0] tx_cred;
	logic              tx_push;
	logic              rx_pop;
	logic              rx_full;

	assign tx_empty_o = (tx_wp == tx_rp);
	assign tx_full_o  = (tx_wp == {~tx_rp[AW], tx_rp[AW-1:0]});
	assign rx_avail_o = (rx_wp != rx_rp);
	assign rx_full    = (rx_wp == {~rx_rp[AW], rx_rp[AW-1:0]});

	// full FIFO drops the write
	assign tx_push    = udr_we_i && !tx_full_o;
	assign rx_pop     = udr_re_i && rx_avail_o;
	// one byte leaves per cycle while a credit is held
	assign tx_valid_o = !tx_empty_o && (tx_cred != '0);
	assign tx_data_o  = tx_mem[tx_rp[AW-1:0]];
	assign rx_data_o  = rx_mem[rx_rp[AW-1:0]];

	always_ff @(posedge iack) begin
		if (tx_push)
			tx_mem[tx_wp[AW-1:0]] <= wdata_i;
		if (rx_valid_i)
			rx_mem[rx_wp[AW-1:0]] <= rx_data_i;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			tx_wp       <= '0;
			tx_rp       <= '0;
			rx_wp       <= '0;
			rx_rp       <= '0;
			tx_cred     <= '0;
			rx_credit_o <= 1'b0;
		end else begin
			if (tx_push)
				tx_wp <= tx_wp + 1'b1;
			if (tx_valid_o)
				tx_rp <= tx_rp + 1'b1;
			if (rx_valid_i)
				rx_wp <= rx_wp + 1'b1;
			if (rx_pop)
				rx_rp <= rx_rp + 1'b1;
			// credit in and byte out may meet in one cycle
			tx_cred     <= tx_cred + CREDIT_W'(tx_credit_i) - CREDIT_W'(tx_valid_o);
			// the freed slot goes back to the I/O controller
			rx_credit_o <= rx_pop;
		end
	end

	// I/O controller must hold a credit, so the FIFO has room
	a_rx_room: assert property (@(posedge iack) disable iff (reset)
		rx_valid_i |-> !rx_full)
		else $error("receive byte with full FIFO");

	a_tx_cred: assert property (@(posedge iack) disable iff (reset)
		(tx_credit_i && !tx_valid_o) |-> (tx_cred != '1))
		else $error("transmit credit overflow");

endmodule

`default_nettype wire

/* verilog/mfp_top.sv */
// MFP lite top level
`timescale 1ns/1ps
`default_nettype none

module mfp_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int CREDIT_W   = 3
) (
	input  wire               iack,
	input  wire               reset,
	input  wire               sel_i,
	input  wire               we_i,
	input  mfp_pkg::mfp_addr_t addr_i,
	input  wire  [7:0]        wdata_i,
	output logic [7:0]        rdata_o,
	input  wire               int_ack_i,
	input  wire  [7:0]        gpio_i,
	output logic [7:0]        gpio_o,
	output logic [7:0]        gpio_oe_o,
	output logic              irq_o,
	input  wire               tx_credit_i,
	output logic              tx_valid_o,
	output logic [7:0]        tx_data_o,
	input  wire               rx_valid_i,
	input  wire  [7:0]        rx_data_i,
	output logic              rx_credit_o
);
	import mfp_pkg::*;

	logic [3:0] edge_w;
	logic       ta_ctrl_we, ta_data_we, tb_ctrl_we, tb_data_we;
	logic [2:0] ta_ctrl, tb_ctrl;
	logic [7:0] ta_data, tb_data;
	logic       ta_done, tb_done;
	logic [4:0] intc_we;
	logic [7:0] ier, ipr, isr, imr, vr, vector;
	logic       udr_we, udr_re;
	logic [7:0] rx_byte;
	logic       rx_avail, tx_full, tx_empty;
	logic [7:0] src;

	// sources in package priority order
	always_comb begin
		src               = 8'h00;
		src[SRC_GPIO0]    = edge_w[0];
		src[SRC_GPIO1]    = edge_w[1];
		src[SRC_GPIO2]    = edge_w[2];
		src[SRC_GPIO3]    = edge_w[3];
		src[SRC_TIMER_B]  = tb_done;
		src[SRC_TX_EMPTY] = tx_empty;
		src[SRC_RX_FULL]  = rx_avail;
		src[SRC_TIMER_A]  = ta_done;
	end

	mfp_bus bus_u (
		.iack(iack), .reset(reset), .sel_i(sel_i), .we_i(we_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .rdata_o(rdata_o), .int_ack_i(int_ack_i),
		.gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .edge_o(edge_w),
		.ta_ctrl_we_o(ta_ctrl_we), .ta_data_we_o(ta_data_we),
		.tb_ctrl_we_o(tb_ctrl_we), .tb_data_we_o(tb_data_we),
		.ta_ctrl_i(ta_ctrl), .ta_data_i(ta_data), .tb_ctrl_i(tb_ctrl), .tb_data_i(tb_data),
		.intc_we_o(intc_we), .ier_i(ier), .ipr_i(ipr), .isr_i(isr), .imr_i(imr),
		.vr_i(vr), .vector_i(vector), .udr_we_o(udr_we), .udr_re_o(udr_re),
		.rx_data_i(rx_byte), .rx_avail_i(rx_avail), .tx_full_i(tx_full)
	);

	mfp_timer ta_u (
		.iack(iack), .reset(reset), .ctrl_we_i(ta_ctrl_we), .data_we_i(ta_data_we),
		.wdata_i(wdata_i), .ctrl_o(ta_ctrl), .data_o(ta_data), .done_o(ta_done)
	);

	mfp_timer tb_u (
		.iack(iack), .reset(reset), .ctrl_we_i(tb_ctrl_we), .data_we_i(tb_data_we),
		.wdata_i(wdata_i), .ctrl_o(tb_ctrl), .data_o(tb_data), .done_o(tb_done)
	);

	mfp_intc intc_u (
		.iack(iack), .reset(reset), .src_i(src), .we_i(intc_we), .wdata_i(wdata_i),
		.int_ack_i(int_ack_i), .ier_o(ier), .ipr_o(ipr), .isr_o(isr), .imr_o(imr),
		.vr_o(vr), .vector_o(vector), .irq_o(irq_o)
	);

	mfp_serial #(.FIFO_DEPTH(FIFO_DEPTH), .CREDIT_W(CREDIT_W)) serial_u (
		.iack(iack), .reset(reset), .udr_we_i(udr_we), .udr_re_i(udr_re),
		.wdata_i(wdata_i), .rx_data_o(rx_byte), .rx_avail_o(rx_avail),
		.tx_full_o(tx_full), .tx_empty_o(tx_empty), .tx_credit_i(tx_credit_i),
		.tx_valid_o(tx_valid_o), .tx_data_o(tx_data_o), .rx_valid_i(rx_valid_i),
		.rx_data_i(rx_data_i), .rx_credit_o(rx_credit_o)
	);

endmodule

`default_nettype wire

/* tests/mfp_checker.sv */
// MFP result checker
`timescale 1ns/1ps
`default_nettype none

module mfp_checker (
	input  logic       iack,
	input  logic       reset,
	input  logic [7:0] rdata_i,
	input  logic       irq_i,
	input  logic [7:0] gpio_out_i,
	input  logic [7:0] gpio_oe_i,
	input  logic       tx_valid_i,
	input  logic [7:0] tx_data_i,
	input  logic       rx_credit_i,
	// expectation posted by the testbench for the coming edge
	input  logic       cmp_en_i,
	input  logic [1:0] cmp_kind_i,
	input  logic [7:0] cmp_exp_i,
	input  int         cmp_val_i,
	input  int         cmp_lo_i,
	input  int         cmp_hi_i,
	input  logic [7:0] tx_exp_i,
	input  int         tx_credits_i,
	output int         tx_seen_o,
	output int         rx_credits_o,
	output int         checks_o,
	output int         errors_o
);
	int cmp_checks;
	int cmp_errors;
	int tx_errors;

	assign checks_o = cmp_checks + tx_seen_o;
	assign errors_o = cmp_errors + tx_errors;

	// kind 0 read data, kind 1 irq level, kind 2 value within a window
	// kind 3 port outputs, oe above out in the low half of the value
	always @(posedge iack) begin
		if (reset) begin
			cmp_checks <= 0;
			cmp_errors <= 0;
		end else if (cmp_en_i) begin
			cmp_checks <= cmp_checks + 1;
			if (cmp_kind_i == 2'd0 && rdata_i !== cmp_exp_i) begin
				$display("Fail %0t: read data %h, expected %h", $time, rdata_i, cmp_exp_i);
				cmp_errors <= cmp_errors + 1;
			end else if (cmp_kind_i == 2'd1 && irq_i !== cmp_exp_i[0]) begin
				$display("Fail %0t: irq %b, expected %b", $time, irq_i, cmp_exp_i[0]);
				cmp_errors <= cmp_errors + 1;
			end else if (cmp_kind_i == 2'd2 &&
					(cmp_val_i < cmp_lo_i || cmp_val_i > cmp_hi_i)) begin
				$display("Fail %0t: interval %0d outside %0d..%0d", $time,
					cmp_val_i, cmp_lo_i, cmp_hi_i);
				cmp_errors <= cmp_errors + 1;
			end else if (cmp_kind_i == 2'd3 &&
					{gpio_oe_i, gpio_out_i} !== cmp_val_i[15:0]) begin
				$display("Fail %0t: port oe %h out %h, expected oe %h out %h", $time,
					gpio_oe_i, gpio_out_i, cmp_val_i[15:8], cmp_val_i[7:0]);
				cmp_errors <= cmp_errors + 1;
			end
		end
	end

	// transmit bytes in order, never more than the credits handed out
	always @(posedge iack) begin
		if (reset) begin
			tx_seen_o <= 0;
			tx_errors <= 0;
		end else if (tx_valid_i) begin
			tx_seen_o <= tx_seen_o + 1;
			if (tx_data_i !== tx_exp_i) begin
				$display("Fail %0t: tx byte %h, expected %h", $time, tx_data_i, tx_exp_i);
				tx_errors <= tx_errors + 1;
			end else if (tx_seen_o >= tx_credits_i) begin
				$display("Fail %0t: tx byte sent without credit", $time);
				tx_errors <= tx_errors + 1;
			end
		end
	end

	// returned receive credits
	always @(posedge iack) begin
		if (reset)
			rx_credits_o <= 0;
		else if (rx_credit_i)
			rx_credits_o <= rx_credits_o + 1;
	end

endmodule

`default_nettype wire

/* tests/mfp_tb.sv */
// MFP lite testbench
`timescale 1ns/1ps
`default_nettype none

module mfp_tb;
	import mfp_pkg::*;

	logic       iack;
	logic       reset;
	logic       sel, we, int_ack, tx_credit, rx_valid;
	logic [3:0] addr;
	logic [7:0] wdata, rx_data, gpio_in;
	logic [7:0] rdata, gpio_out, gpio_oe, tx_data;
	logic       irq, tx_valid, rx_credit;
	// comparison channel toward the checker
	logic       cmp_en;
	logic [1:0] cmp_kind;
	logic [7:0] cmp_exp, tx_exp;
	int         cmp_val, cmp_lo, cmp_hi;
	int         credits_given, tx_seen, rx_returned, checks, errors, timeouts, cyc;
	logic [31:0] seed;
	// model state
	logic [7:0] m_gpip, m_aer, m_ddr, m_ier, m_ipr, m_isr, m_imr, m_vr, m_tadr, m_tbdr;
	logic [7:0] tx_q [32];
	logic [7:0] rx_q [32];
	int         tx_acc, rx_wr, rx_rd;
	int         n, p, t0, t1;
	logic [7:0] b;

	mfp_top #(.FIFO_DEPTH(4), .CREDIT_W(3)) DUT (
		.iack(iack), .reset(reset), .sel_i(sel), .we_i(we), .addr_i(addr),
		.wdata_i(wdata), .rdata_o(rdata), .int_ack_i(int_ack), .gpio_i(gpio_in),
		.gpio_o(gpio_out), .gpio_oe_o(gpio_oe), .irq_o(irq), .tx_credit_i(tx_credit),
		.tx_valid_o(tx_valid), .tx_data_o(tx_data), .rx_valid_i(rx_valid),
		.rx_data_i(rx_data), .rx_credit_o(rx_credit)
	);

	mfp_checker chk_u (
		.iack(iack), .reset(reset), .rdata_i(rdata), .irq_i(irq),
		.gpio_out_i(gpio_out), .gpio_oe_i(gpio_oe), .tx_valid_i(tx_valid),
		.tx_data_i(tx_data), .rx_credit_i(rx_credit), .cmp_en_i(cmp_en),
		.cmp_kind_i(cmp_kind), .cmp_exp_i(cmp_exp), .cmp_val_i(cmp_val),
		.cmp_lo_i(cmp_lo), .cmp_hi_i(cmp_hi), .tx_exp_i(tx_exp),
		.tx_credits_i(credits_given), .tx_seen_o(tx_seen), .rx_credits_o(rx_returned),
		.checks_o(checks), .errors_o(errors)
	);

	assign tx_exp = tx_q[tx_seen];

	initial begin
		iack = 1'b0;
		forever #2 iack = ~iack;
	end

	always @(posedge iack)
		cyc <= cyc + 1;

	function automatic logic [31:0] rand_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// top byte of the LCG, the low bits repeat quickly
	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = rand_next();
		return r[31:24];
	endfunction

	// index of the highest set bit, -1 when none
	function automatic int highest_bit(input logic [7:0] v);
		int r;
		r = -1;
		for (int i = 0; i < 8; i++)
			if (v[i])
				r = i;
		return r;
	endfunction

	// bytes gone out once the FIFO has drained, one credit each
	function automatic int tx_sent();
		return (tx_acc < credits_given) ? tx_acc : credits_given;
	endfunction

	// reference model: expected register value, irq level and vector
	function automatic logic [7:0] ref_read(input logic [3:0] a);
		case (a)
			ADDR_GPIP: return (gpio_in & ~m_ddr) | (m_gpip & m_ddr);
			ADDR_AER:  return m_aer;
			ADDR_DDR:  return m_ddr;
			ADDR_IER:  return m_ier;
			ADDR_IPR:  return m_ipr;
			ADDR_ISR:  return m_isr;
			ADDR_IMR:  return m_imr;
			ADDR_VR:   return m_vr;
			ADDR_TADR: return m_tadr;
			ADDR_TBDR: return m_tbdr;
			ADDR_RSR:  return {rx_wr != rx_rd, 7'b0};
			ADDR_TSR:  return {(tx_acc - tx_sent()) < 4, 7'b0};
			ADDR_UDR:  return rx_q[rx_rd];
			default:   return 8'h00;
		endcase
	endfunction

	function automatic logic ref_irq();
		int pend;
		int serv;
		pend = highest_bit(m_ipr & m_imr);
		serv = highest_bit(m_isr);
		return (pend >= 0) && (pend > serv);
	endfunction

	function automatic logic [7:0] ref_vector();
		return {m_vr[7:4], 1'b0, 3'(highest_bit(m_ipr & m_imr))};
	endfunction

	task automatic cpu_write(input logic [3:0] a, input logic [7:0] d);
		@(negedge iack);
		{sel, we, addr, wdata} = {1'b1, 1'b1, a, d};
		@(negedge iack);
		{sel, we} = 2'b00;
		case (a)
			ADDR_GPIP: m_gpip = d;
			ADDR_AER:  m_aer = d;
			ADDR_DDR:  m_ddr = d;
			ADDR_IER: begin
				m_ier = d;
				m_ipr = m_ipr & d;
			end
			ADDR_IPR:  m_ipr = m_ipr & d;
			ADDR_ISR:  m_isr = m_isr & d;
			ADDR_IMR:  m_imr = d;
			ADDR_VR:   m_vr = d;
			ADDR_TADR: m_tadr = d;
			ADDR_TBDR: m_tbdr = d;
			ADDR_UDR: begin
				if (tx_acc - tx_sent() < 4) begin
					tx_q[tx_acc] = d;
					tx_acc++;
				end
			end
			default: ;
		endcase
	endtask

	task automatic post_check(input logic [1:0] kind, input logic [7:0] e);
		cmp_en   = 1'b1;
		cmp_kind = kind;
		cmp_exp  = e;
	endtask

	task automatic cpu_read(input logic [3:0] a);
		@(negedge iack);
		{sel, we, addr} = {1'b1, 1'b0, a};
		post_check(2'd0, ref_read(a));
		@(negedge iack);
		sel    = 1'b0;
		cmp_en = 1'b0;
		if (a == ADDR_UDR && rx_wr != rx_rd)
			rx_rd++;
	endtask

	task automatic check_irq();
		@(negedge iack);
		post_check(2'd1, {7'b0, ref_irq()});
		@(negedge iack);
		cmp_en = 1'b0;
	endtask

	task automatic check_range(input int v, input int lo, input int hi);
		@(negedge iack);
		{cmp_val, cmp_lo, cmp_hi} = {v, lo, hi};
		post_check(2'd2, 8'h00);
		@(negedge iack);
		cmp_en = 1'b0;
	endtask

	// output enables follow DDR, outputs follow the GPIP latch
	task automatic check_port();
		@(negedge iack);
		cmp_val = {16'h0000, m_ddr, m_gpip};
		post_check(2'd3, 8'h00);
		@(negedge iack);
		cmp_en = 1'b0;
	endtask

	// acknowledge, then move the winner out of pending
	task automatic cpu_ack();
		int ch;
		@(negedge iack);
		int_ack = 1'b1;
		post_check(2'd0, ref_vector());
		@(negedge iack);
		int_ack = 1'b0;
		cmp_en  = 1'b0;
		ch = highest_bit(m_ipr & m_imr);
		m_ipr[ch] = 1'b0;
		if (!m_vr[3])
			m_isr[ch] = 1'b1;
	endtask

	// new pin levels, pending bits for enabled active edges
	task automatic set_pins(input logic [7:0] v);
		@(negedge iack);
		for (int i = 0; i < 4; i++)
			if (v[i] != gpio_in[i] && v[i] == m_aer[i] && m_ier[i])
				m_ipr[i] = 1'b1;
		gpio_in = v;
		repeat (2) @(negedge iack);
	endtask

	task automatic wait_irq(input int limit);
		int k;
		k = 0;
		while (!irq && k < limit) begin
			@(negedge iack);
			k++;
		end
		if (!irq) begin
			$display("timeout: no interrupt request from timer A");
			timeouts++;
		end
	endtask

	task automatic wait_tx(input int target);
		int k;
		k = 0;
		while (tx_seen < target && k < 200) begin
			@(negedge iack);
			k++;
		end
		if (tx_seen < target) begin
			$display("timeout: transmit bytes did not come out");
			timeouts++;
		end
	endtask

	task automatic give_credit();
		@(negedge iack);
		tx_credit = 1'b1;
		credits_given++;
		@(negedge iack);
		tx_credit = 1'b0;
		repeat (rand_next() % 3) @(negedge iack);
	endtask

	task automatic send_rx(input logic [7:0] d);
		@(negedge iack);
		rx_valid = 1'b1;
		rx_data  = d;
		rx_q[rx_wr] = d;
		rx_wr++;
		@(negedge iack);
		rx_valid = 1'b0;
	endtask

	initial begin
		seed = 32'hcbcd5181;
		{sel, we, int_ack, tx_credit, rx_valid, cmp_en} = '0;
		{addr, wdata, rx_data, gpio_in, cmp_kind, cmp_exp} = '0;
		{cmp_val, cmp_lo, cmp_hi, credits_given, timeouts, cyc} = '0;
		{m_gpip, m_aer, m_ddr, m_ier, m_ipr, m_isr, m_imr, m_vr, m_tadr, m_tbdr} = '0;
		{tx_acc, rx_wr, rx_rd} = '0;
		reset = 1'b1;
		repeat (16) @(posedge iack);
		@(negedge iack);
		reset = 1'b0;

		// registers and port, sources disabled
		cpu_write(ADDR_AER, rand_byte());
		cpu_write(ADDR_DDR, rand_byte());
		cpu_write(ADDR_GPIP, rand_byte());
		cpu_write(ADDR_IMR, rand_byte());
		cpu_write(ADDR_VR, rand_byte());
		cpu_write(ADDR_TADR, rand_byte());
		cpu_write(ADDR_TBDR, rand_byte());
		for (logic [3:0] a = ADDR_GPIP; a <= ADDR_TBDR; a++)
			cpu_read(a);
		for (int i = 0; i < 4; i++) begin
			set_pins(rand_byte());
			cpu_read(ADDR_GPIP);
			check_port();
		end

		// GPIO edge interrupts
		cpu_write(ADDR_IMR, 8'h00);
		cpu_write(ADDR_AER, rand_byte());
		cpu_write(ADDR_IER, 8'h0f);
		for (int i = 0; i < 16; i++) begin
			set_pins(rand_byte());
			cpu_read(ADDR_IPR);
		end
		cpu_write(ADDR_IPR, 8'h00);
		cpu_read(ADDR_IPR);

		// timer A period with automatic end of interrupt
		cpu_write(ADDR_IER, 8'h80);
		cpu_write(ADDR_IMR, 8'h80);
		cpu_write(ADDR_VR, (rand_byte() & 8'hf0) | 8'h08);
		n = 2 + rand_next() % 4;
		b = 8'(1 + rand_next() % 2);
		p = mfp_prescale(b[2:0]);
		cpu_write(ADDR_TADR, 8'(n));
		cpu_write(ADDR_TACR, b);
		t0 = cyc;
		wait_irq(2000);
		t1 = cyc;
		check_range(t1 - t0, n * p - p, n * p + p + 2);
		m_ipr[7] = 1'b1;
		cpu_ack();
		wait_irq(2000);
		check_range(cyc - t1, n * p - p, n * p + p);
		cpu_write(ADDR_TACR, 8'h00);
		cpu_write(ADDR_IER, 8'h00);
		cpu_read(ADDR_ISR);

		// priority, in-service blocking and vectors
		cpu_write(ADDR_AER, 8'h0f);
		set_pins(8'h00);
		cpu_write(ADDR_IER, 8'h0f);
		cpu_write(ADDR_IMR, 8'h0f);
		cpu_write(ADDR_VR, rand_byte() & 8'hf0);
		set_pins(8'h0a);
		check_irq();
		cpu_ack();
		check_irq();
		cpu_read(ADDR_ISR);
		cpu_write(ADDR_ISR, 8'h00);
		check_irq();
		cpu_ack();
		cpu_write(ADDR_ISR, 8'h00);
		cpu_write(ADDR_VR, (rand_byte() & 8'hf0) | 8'h08);
		set_pins(8'h0e);
		cpu_ack();
		cpu_read(ADDR_ISR);
		check_irq();
		cpu_write(ADDR_IER, 8'h00);
		cpu_write(ADDR_IMR, 8'h00);

		// transmit, fill without credit then drain
		cpu_read(ADDR_TSR);
		for (int i = 0; i < 5; i++) begin
			cpu_write(ADDR_UDR, rand_byte());
			cpu_read(ADDR_TSR);
		end
		repeat (4) give_credit();
		wait_tx(4);
		cpu_read(ADDR_TSR);
		for (int i = 0; i < 6; i++) begin
			give_credit();
			cpu_write(ADDR_UDR, rand_byte());
			wait_tx(tx_acc);
		end

		// receive under credit, two rounds
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 4; i++)
				if (rx_wr - rx_returned < 4)
					send_rx(rand_byte());
			cpu_read(ADDR_RSR);
			for (int i = 0; i < 4; i++)
				cpu_read(ADDR_UDR);
			cpu_read(ADDR_RSR);
			for (int k = 0; k < 50 && rx_returned < rx_rd; k++)
				@(negedge iack);
			if (rx_returned != rx_rd) begin
				$display("timeout: receive credits do not match the bytes read");
				timeouts++;
			end
		end

		repeat (4) @(negedge iack);
		$display("checks %0d, errors %0d, other failures %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* mfp_lite.f */
verilog/mfp_pkg.sv
verilog/mfp_bus.sv
verilog/mfp_timer.sv
verilog/mfp_intc.sv
verilog/mfp_serial.sv
verilog/mfp_top.sv
tests/mfp_checker.sv
tests/mfp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mfp_lite testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module mfp_tb \
	-f mfp_lite.f \
	-o mfp_sim

./obj_dir/mfp_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
